/* src/decode_settings.svh */
`ifndef DECODE_SETTINGS_SVH
`define DECODE_SETTINGS_SVH

// data and address width
`define XLEN       32

// register file geometry
`define REG_ADDR_W 5
`define REG_COUNT  32

// addi x0, x0, 0
`define NOP_IR     32'h0000_0013

// sentinel pc carried by a bubble
`define NOP_PC     {`XLEN{1'b1}}

`endif

/* src/decode_pkg.sv */
`include "decode_settings.svh"

package decode_pkg;

    typedef logic [`XLEN-1:0]       word_t;
    typedef logic [`REG_ADDR_W-1:0] regaddr_t;

    // major opcodes, instruction bits [6:0]
    typedef enum logic [6:0] {
        OP_LOAD     = 7'b0000011,
        OP_MISC_MEM = 7'b0001111,
        OP_IMM      = 7'b0010011,
        OP_AUIPC    = 7'b0010111,
        OP_STORE    = 7'b0100011,
        OP          = 7'b0110011,
        OP_LUI      = 7'b0110111,
        OP_BRANCH   = 7'b1100011,
        OP_JALR     = 7'b1100111,
        OP_JAL      = 7'b1101111,
        OP_SYSTEM   = 7'b1110011   // no csr support, decodes as illegal
    } opcode_t;

    // {funct7[0], funct7[5], funct3} or {2'b00, funct3}
    typedef logic [4:0] alu_mode_t;
    localparam alu_mode_t ALU_ADD   = 5'b00000;
    localparam alu_mode_t ALU_COPY1 = 5'b11000;  // pass operand 1 through

    typedef enum logic [1:0] {OP1_NONE, OP1_RS1, OP1_IMMU} op1_sel_t;
    typedef enum logic [2:0] {OP2_NONE, OP2_RS2, OP2_IMMI, OP2_IMMS, OP2_PC} op2_sel_t;
    typedef enum logic [1:0] {PC_NEXT, PC_JUMP_REL, PC_JUMP_ABS, PC_BRANCH} pc_mode_t;
    typedef enum logic [1:0] {MA_NONE, MA_LOAD, MA_STORE} ma_mode_t;
    typedef logic [2:0] ma_size_t;  // same encoding as funct3
    typedef enum logic [1:0] {WB_NONE, WB_ALU, WB_MEM, WB_PC4} wb_src_t;

    // instruction formats, fields listed msb first
    typedef struct packed {
        logic [6:0] funct7;
        regaddr_t   rs2;
        regaddr_t   rs1;
        logic [2:0] funct3;
        regaddr_t   rd;
        opcode_t    opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm;
        regaddr_t    rs1;
        logic [2:0]  funct3;
        regaddr_t    rd;
        opcode_t     opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0] imm_11_5;
        regaddr_t   rs2;
        regaddr_t   rs1;
        logic [2:0] funct3;
        logic [4:0] imm_4_0;
        opcode_t    opcode;
    } s_fmt_t;

    typedef struct packed {
        logic       imm_12;
        logic [5:0] imm_10_5;
        regaddr_t   rs2;
        regaddr_t   rs1;
        logic [2:0] funct3;
        logic [3:0] imm_4_1;
        logic       imm_11;
        opcode_t    opcode;
    } b_fmt_t;

    typedef struct packed {
        logic [19:0] imm_31_12;
        regaddr_t    rd;
        opcode_t     opcode;
    } u_fmt_t;

    typedef struct packed {
        logic       imm_20;
        logic [9:0] imm_10_1;
        logic       imm_11;
        logic [7:0] imm_19_12;
        regaddr_t   rd;
        opcode_t    opcode;
    } j_fmt_t;

    typedef union packed {
        r_fmt_t r_fmt;
        i_fmt_t i_fmt;
        s_fmt_t s_fmt;
        b_fmt_t b_fmt;
        u_fmt_t u_fmt;
        j_fmt_t j_fmt;
    } instr_u;

    typedef struct packed {
        logic      halt;
        pc_mode_t  pc_mode;
        op1_sel_t  op1_sel;
        op2_sel_t  op2_sel;
        alu_mode_t alu_mode;
        ma_mode_t  ma_mode;
        ma_size_t  ma_size;
        wb_src_t   wb_src;
        logic      rs1_used;
        logic      rs2_used;
    } ctrl_word_t;

    typedef struct packed {
        word_t imm_i;
        word_t imm_s;
        word_t imm_b;
        word_t imm_u;
        word_t imm_j;
    } imm_set_t;

    // result in flight in ex or ma, ready once data is valid
    typedef struct packed {
        logic     valid;
        logic     ready;
        regaddr_t addr;
        word_t    data;
    } fwd_port_t;

    typedef struct packed {
        logic     valid;
        regaddr_t addr;
        word_t    data;
    } wb_port_t;

    typedef struct packed {
        word_t     pc;
        word_t     ir;
        word_t     alu_op1;
        word_t     alu_op2;
        alu_mode_t alu_mode;
        ma_mode_t  ma_mode;
        ma_size_t  ma_size;
        word_t     ma_data;   // store data
        wb_src_t   wb_src;
        word_t     wb_data;   // link address
        logic      wb_valid;
        logic      halt;
    } id_ex_t;

endpackage

/* src/instr_decoder.sv */
module instr_decoder (
    input  decode_pkg::word_t      ir_i,
    output decode_pkg::ctrl_word_t ctrl_o,
    output decode_pkg::imm_set_t   imm_o
);
    import decode_pkg::*;

    // unrecognised encoding, every action off
    localparam ctrl_word_t CW_HALT = '{
        halt:     1'b1,
        pc_mode:  PC_NEXT,
        op1_sel:  OP1_NONE,
        op2_sel:  OP2_NONE,
        alu_mode: ALU_ADD,
        ma_mode:  MA_NONE,
        ma_size:  3'b000,
        wb_src:   WB_NONE,
        rs1_used: 1'b0,
        rs2_used: 1'b0
    };

    instr_u     ir;
    logic [6:0] f7;
    logic [2:0] f3;
    opcode_t    opc;
    alu_mode_t  mode7;
    alu_mode_t  mode3;

    // used is {rs1, rs2}
    function automatic ctrl_word_t cw(pc_mode_t pc, op1_sel_t op1, op2_sel_t op2,
                                      alu_mode_t mode, ma_mode_t ma, wb_src_t wb,
                                      logic [1:0] used);
        ctrl_word_t c;
        c = '{halt: 1'b0, pc_mode: pc, op1_sel: op1, op2_sel: op2, alu_mode: mode,
              ma_mode: ma, ma_size: 3'b000, wb_src: wb, rs1_used: used[1],
              rs2_used: used[0]};
        return c;
    endfunction

    always_comb begin
        ir    = ir_i;
        f7    = ir.r_fmt.funct7;
        f3    = ir.r_fmt.funct3;
        opc   = ir.r_fmt.opcode;
        mode7 = {f7[0], f7[5], f3};
        mode3 = {2'b00, f3};
    end

    // sign-extended immediates
    always_comb begin
        imm_o.imm_i = word_t'($signed(ir.i_fmt.imm));
        imm_o.imm_s = word_t'($signed({ir.s_fmt.imm_11_5, ir.s_fmt.imm_4_0}));
        imm_o.imm_b = word_t'($signed({ir.b_fmt.imm_12, ir.b_fmt.imm_11, ir.b_fmt.imm_10_5,
                                       ir.b_fmt.imm_4_1, 1'b0}));
        imm_o.imm_u = {ir.u_fmt.imm_31_12, 12'b0};
        imm_o.imm_j = word_t'($signed({ir.j_fmt.imm_20, ir.j_fmt.imm_19_12, ir.j_fmt.imm_11,
                                       ir.j_fmt.imm_10_1, 1'b0}));
    end

    always_comb begin
        casez ({f7, f3, opc})
            // shift immediates keep funct7 so SRAI and SRLI differ
            {7'b0000000, 3'b001, OP_IMM},
            {7'b0?00000, 3'b101, OP_IMM}:
                ctrl_o = cw(PC_NEXT, OP1_RS1, OP2_IMMI, mode7, MA_NONE, WB_ALU, 2'b10);
            {7'b???????, 3'b?01, OP_IMM},   // bad shift funct7
            {7'b???????, 3'b01?, OP_BRANCH},
            {7'b???????, 3'b011, OP_LOAD},
            {7'b???????, 3'b11?, OP_LOAD},
            {7'b???????, 3'b011, OP_STORE},
            {7'b???????, 3'b1??, OP_STORE},
            {7'b???????, 3'b???, OP_SYSTEM}:
                ctrl_o = CW_HALT;
            {7'b???????, 3'b???, OP_IMM}:
                ctrl_o = cw(PC_NEXT, OP1_RS1, OP2_IMMI, mode3, MA_NONE, WB_ALU, 2'b10);
            {7'b0000000, 3'b???, OP},
            {7'b0000001, 3'b???, OP},       // mul/div group
            {7'b0100000, 3'b000, OP},       // sub
            {7'b0100000, 3'b101, OP}:       // sra
                ctrl_o = cw(PC_NEXT, OP1_RS1, OP2_RS2, mode7, MA_NONE, WB_ALU, 2'b11);
            {7'b???????, 3'b???, OP_LUI}:
                ctrl_o = cw(PC_NEXT, OP1_IMMU, OP2_NONE, ALU_COPY1, MA_NONE, WB_ALU, 2'b00);
            {7'b???????, 3'b???, OP_AUIPC}:
                ctrl_o = cw(PC_NEXT, OP1_IMMU, OP2_PC, ALU_ADD, MA_NONE, WB_ALU, 2'b00);
            {7'b???????, 3'b???, OP_JAL}:
                ctrl_o = cw(PC_JUMP_REL, OP1_NONE, OP2_NONE, ALU_ADD, MA_NONE, WB_PC4, 2'b00);
            {7'b???????, 3'b000, OP_JALR}:
                ctrl_o = cw(PC_JUMP_ABS, OP1_NONE, OP2_NONE, ALU_ADD, MA_NONE, WB_PC4, 2'b10);
            {7'b???????, 3'b???, OP_BRANCH}:  // condition travels in alu_mode
                ctrl_o = cw(PC_BRANCH, OP1_NONE, OP2_NONE, mode3, MA_NONE, WB_NONE, 2'b11);
            {7'b???????, 3'b???, OP_LOAD}:
                ctrl_o = cw(PC_NEXT, OP1_RS1, OP2_IMMI, ALU_ADD, MA_LOAD, WB_MEM, 2'b10);
            {7'b???????, 3'b???, OP_STORE}:
                ctrl_o = cw(PC_NEXT, OP1_RS1, OP2_IMMS, ALU_ADD, MA_STORE, WB_NONE, 2'b11);
            {7'b???????, 3'b???, OP_MISC_MEM}:  // fence retires as a nop
                ctrl_o = cw(PC_NEXT, OP1_NONE, OP2_NONE, ALU_ADD, MA_NONE, WB_NONE, 2'b00);
            default:
                ctrl_o = CW_HALT;
        endcase
        ctrl_o.ma_size = f3;  // access size for loads and stores
    end

endmodule

/* src/regfile.sv */
`include "decode_settings.svh"

module regfile (
    input  logic                 clk_i,
    input  logic                 reset_i,
    input  decode_pkg::regaddr_t rd1_addr_i,
    output decode_pkg::word_t    rd1_data_o,
    input  decode_pkg::regaddr_t rd2_addr_i,
    output decode_pkg::word_t    rd2_data_o,
    input  decode_pkg::wb_port_t wb_i
);
    import decode_pkg::*;

    word_t regs [1:`REG_COUNT-1];  // x0 has no storage

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            for (int i = 1; i < `REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_i.valid && wb_i.addr != '0) begin
            regs[wb_i.addr] <= wb_i.data;
        end
    end

    // asynchronous reads, x0 reads as zero
    assign rd1_data_o = (rd1_addr_i == '0) ? '0 : regs[rd1_addr_i];
    assign rd2_data_o = (rd2_addr_i == '0) ? '0 : regs[rd2_addr_i];

endmodule

/* src/operand_bypass.sv */
module operand_bypass (
    input  decode_pkg::regaddr_t  rs1_i,
    input  decode_pkg::regaddr_t  rs2_i,
    input  logic                  rs1_used_i,
    input  logic                  rs2_used_i,
    input  decode_pkg::word_t     rf1_i,
    input  decode_pkg::word_t     rf2_i,
    input  decode_pkg::fwd_port_t ex_fwd_i,
    input  decode_pkg::fwd_port_t ma_fwd_i,
    input  decode_pkg::wb_port_t  wb_i,
    output decode_pkg::word_t     rs1_val_o,
    output decode_pkg::word_t     rs2_val_o,
    output logic                  hazard_o
);
    import decode_pkg::*;

    // youngest producer wins: ex, then ma, then wb, then the register file
    function automatic word_t pick(regaddr_t rs, word_t rf, fwd_port_t ex,
                                   fwd_port_t ma, wb_port_t wb);
        word_t val;
        if (rs == '0)
            val = '0;
        else if (ex.valid && ex.addr == rs)
            val = ex.data;
        else if (ma.valid && ma.addr == rs)
            val = ma.data;
        else if (wb.valid && wb.addr == rs)
            val = wb.data;
        else
            val = rf;
        return val;
    endfunction

    // producer known but its data not there yet
    function automatic logic waits_on(regaddr_t rs, logic used, fwd_port_t ex,
                                      fwd_port_t ma);
        logic ex_busy;
        logic ma_busy;
        ex_busy = ex.valid && !ex.ready && ex.addr == rs;
        ma_busy = ma.valid && !ma.ready && ma.addr == rs;
        return used && (ex_busy || ma_busy);
    endfunction

    logic rs1_wait;
    logic rs2_wait;

    always_comb begin
        rs1_val_o = pick(rs1_i, rf1_i, ex_fwd_i, ma_fwd_i, wb_i);
        rs2_val_o = pick(rs2_i, rf2_i, ex_fwd_i, ma_fwd_i, wb_i);

        rs1_wait  = waits_on(rs1_i, rs1_used_i, ex_fwd_i, ma_fwd_i);
        rs2_wait  = waits_on(rs2_i, rs2_used_i, ex_fwd_i, ma_fwd_i);
        hazard_o  = rs1_wait || rs2_wait;  // load-use or multi-cycle op ahead
    end

endmodule

/* src/branch_unit.sv */
module branch_unit (
    input  decode_pkg::word_t      pc_i,
    input  decode_pkg::ctrl_word_t ctrl_i,
    input  decode_pkg::imm_set_t   imm_i,
    input  decode_pkg::word_t      rs1_val_i,
    input  decode_pkg::word_t      rs2_val_i,
    input  logic                   hazard_i,
    output logic                   jmp_valid_o,
    output decode_pkg::word_t      jmp_addr_o
);
    import decode_pkg::*;

    logic [2:0] f3;
    logic       taken;

    // f3[2:1] picks the compare, f3[0] negates it
    always_comb begin
        f3 = ctrl_i.alu_mode[2:0];
        case (f3[2:1])
            2'b00:   taken = (rs1_val_i == rs2_val_i);
            2'b10:   taken = ($signed(rs1_val_i) < $signed(rs2_val_i));
            2'b11:   taken = (rs1_val_i < rs2_val_i);
            default: taken = 1'b0;
        endcase
        taken = taken ^ f3[0];
    end

    always_comb begin
        case (ctrl_i.pc_mode)
            PC_JUMP_REL: begin
                jmp_valid_o = 1'b1;  // jal needs no register
                jmp_addr_o  = pc_i + imm_i.imm_j;
            end
            PC_JUMP_ABS: begin
                jmp_valid_o = !hazard_i;
                jmp_addr_o  = rs1_val_i + imm_i.imm_i;
            end
            PC_BRANCH: begin
                jmp_valid_o = taken && !hazard_i;
                jmp_addr_o  = pc_i + imm_i.imm_b;
            end
            default: begin
                jmp_valid_o = 1'b0;
                jmp_addr_o  = '0;
            end
        endcase
    end

endmodule

/* src/decode_stage.sv */
`include "decode_settings.svh"

module decode_stage (
    input  logic                  clk_i,
    input  logic                  reset_i,
    input  decode_pkg::word_t     pc_i,
    input  decode_pkg::word_t     ir_i,
    input  decode_pkg::fwd_port_t ex_fwd_i,
    input  decode_pkg::fwd_port_t ma_fwd_i,
    input  decode_pkg::wb_port_t  wb_i,
    output logic                  ready_o,
    output logic                  jmp_valid_o,
    output decode_pkg::word_t     jmp_addr_o,
    output decode_pkg::id_ex_t    id_ex_o
);
    import decode_pkg::*;

    // addi x0, x0, 0 tagged with the sentinel pc
    localparam id_ex_t BUBBLE = '{
        pc:       `NOP_PC,
        ir:       `NOP_IR,
        alu_op1:  '0,
        alu_op2:  '0,
        alu_mode: ALU_ADD,
        ma_mode:  MA_NONE,
        ma_size:  '0,
        ma_data:  '0,
        wb_src:   WB_NONE,
        wb_data:  '0,
        wb_valid: 1'b0,
        halt:     1'b0
    };

    instr_u     ir;
    ctrl_word_t ctrl;
    imm_set_t   imm;
    word_t      rf1;
    word_t      rf2;
    word_t      rs1_val;
    word_t      rs2_val;
    logic       rs1_used;
    logic       rs2_used;
    logic       hazard;
    logic       jmp_valid;
    word_t      alu_op1;
    word_t      alu_op2;
    id_ex_t     id_ex_next;

    assign ir       = ir_i;
    assign rs1_used = ctrl.rs1_used && (ir.r_fmt.rs1 != '0);  // x0 never waits
    assign rs2_used = ctrl.rs2_used && (ir.r_fmt.rs2 != '0);

    instr_decoder u_decoder (
        .ir_i   (ir_i),
        .ctrl_o (ctrl),
        .imm_o  (imm)
    );

    regfile u_regfile (
        .clk_i      (clk_i),
        .reset_i    (reset_i),
        .rd1_addr_i (ir.r_fmt.rs1),
        .rd1_data_o (rf1),
        .rd2_addr_i (ir.r_fmt.rs2),
        .rd2_data_o (rf2),
        .wb_i       (wb_i)
    );

    operand_bypass u_bypass (
        .rs1_i      (ir.r_fmt.rs1),
        .rs2_i      (ir.r_fmt.rs2),
        .rs1_used_i (rs1_used),
        .rs2_used_i (rs2_used),
        .rf1_i      (rf1),
        .rf2_i      (rf2),
        .ex_fwd_i   (ex_fwd_i),
        .ma_fwd_i   (ma_fwd_i),
        .wb_i       (wb_i),
        .rs1_val_o  (rs1_val),
        .rs2_val_o  (rs2_val),
        .hazard_o   (hazard)
    );

    branch_unit u_branch (
        .pc_i        (pc_i),
        .ctrl_i      (ctrl),
        .imm_i       (imm),
        .rs1_val_i   (rs1_val),
        .rs2_val_i   (rs2_val),
        .hazard_i    (hazard),
        .jmp_valid_o (jmp_valid),
        .jmp_addr_o  (jmp_addr_o)
    );

    // alu operand muxes
    always_comb begin
        case (ctrl.op1_sel)
            OP1_RS1:  alu_op1 = rs1_val;
            OP1_IMMU: alu_op1 = imm.imm_u;
            default:  alu_op1 = '0;
        endcase
        case (ctrl.op2_sel)
            OP2_RS2:  alu_op2 = rs2_val;
            OP2_IMMI: alu_op2 = imm.imm_i;
            OP2_IMMS: alu_op2 = imm.imm_s;
            OP2_PC:   alu_op2 = pc_i;
            default:  alu_op2 = '0;
        endcase
    end

    assign id_ex_next = '{
        pc:       pc_i,
        ir:       ir_i,
        alu_op1:  alu_op1,
        alu_op2:  alu_op2,
        alu_mode: ctrl.alu_mode,
        ma_mode:  ctrl.ma_mode,
        ma_size:  ctrl.ma_size,
        ma_data:  rs2_val,
        wb_src:   ctrl.wb_src,
        wb_data:  pc_i + word_t'(4),
        wb_valid: (ctrl.wb_src != WB_NONE) && (ir.r_fmt.rd != '0),
        halt:     ctrl.halt
    };

    always_ff @(posedge clk_i) begin
        if (reset_i || hazard) begin
            id_ex_o <= BUBBLE;  // fetch holds the stalled instruction
        end else begin
            id_ex_o <= id_ex_next;
        end
    end

    // fetch sees a ready stage and no redirect while in reset
    assign ready_o     = reset_i || !hazard;
    assign jmp_valid_o = jmp_valid && !reset_i;

endmodule

/* verification/decode_stage_tb.sv */
`include "decode_settings.svh"

module decode_stage_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import decode_pkg::*;

    localparam int N_BRANCH = 24;             // six conditions, four operand pairs each
    localparam int N_ISSUE  = 56 + N_BRANCH;  // upper bound on issue slots incl. reset
    localparam int T_RESET  = 0;
    localparam int T_ALU    = 1;
    localparam int T_FWD    = 2;
    localparam int T_HAZ    = 3;
    localparam int T_BR     = 4;
    localparam int T_MEM    = 5;

    logic      clk_i;
    logic      reset_i;
    word_t     pc_i;
    word_t     ir_i;
    fwd_port_t ex_fwd_i;
    fwd_port_t ma_fwd_i;
    wb_port_t  wb_i;
    logic      ready_o;
    logic      jmp_valid_o;
    word_t     jmp_addr_o;
    id_ex_t    id_ex_o;

    // port values for the next issue
    fwd_port_t ex_p;
    fwd_port_t ma_p;
    wb_port_t  wb_p;
    word_t     shadow [0:31];  // expected register file contents
    word_t     cur_pc;
    word_t     lcg_state;
    int        cur_test;

    logic   chk;
    logic   chk_d;
    id_ex_t exp_ex;
    id_ex_t exp_ex_d;
    logic   exp_jv;
    logic   exp_rdy;
    word_t  exp_ja;
    int     tid;
    int     tid_d;
    int     err_ex;
    int     err_jmp;
    int     err_rdy;
    string  names [0:5] = '{"reset", "alu", "forward", "hazard", "branch", "mem_illegal"};

    decode_stage uut (
        .clk_i       (clk_i),
        .reset_i     (reset_i),
        .pc_i        (pc_i),
        .ir_i        (ir_i),
        .ex_fwd_i    (ex_fwd_i),
        .ma_fwd_i    (ma_fwd_i),
        .wb_i        (wb_i),
        .ready_o     (ready_o),
        .jmp_valid_o (jmp_valid_o),
        .jmp_addr_o  (jmp_addr_o),
        .id_ex_o     (id_ex_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #10 clk_i = ~clk_i;
    end

    // id_ex_o lags the issue cycle by one edge
    always @(posedge clk_i) begin
        chk_d    <= chk;
        exp_ex_d <= exp_ex;
        tid_d    <= tid;
    end

    ex_check: assert property (@(posedge clk_i) chk_d |-> id_ex_o == exp_ex_d)
        else begin
            err_ex++;
            $display("ERROR %s: id_ex expected %h, actual %h", names[$sampled(tid_d)],
                     $sampled(exp_ex_d), $sampled(id_ex_o));
        end

    jump_check: assert property (@(posedge clk_i)
            chk |-> jmp_valid_o == exp_jv && (!exp_jv || jmp_addr_o == exp_ja))
        else begin
            err_jmp++;
            $display("ERROR %s: jump expected %b/%h, actual %b/%h", names[$sampled(tid)],
                     $sampled(exp_jv), $sampled(exp_ja), $sampled(jmp_valid_o),
                     $sampled(jmp_addr_o));
        end

    ready_check: assert property (@(posedge clk_i) chk |-> ready_o == exp_rdy)
        else begin
            err_rdy++;
            $display("ERROR %s: ready expected %b, actual %b", names[$sampled(tid)],
                     $sampled(exp_rdy), $sampled(ready_o));
        end

    initial begin
        #(N_ISSUE * 20 + 400);
        $display("watchdog expired, the tests did not finish in time");
        $display("Verification failed");
        $finish;
    end

    function automatic word_t rand_word();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic word_t sext12(logic [11:0] v);
        return {{20{v[11]}}, v};
    endfunction

    function automatic word_t rtype(logic [6:0] f7, regaddr_t rs2, regaddr_t rs1,
                                    logic [2:0] f3, regaddr_t rd, logic [6:0] opc);
        return {f7, rs2, rs1, f3, rd, opc};
    endfunction

    function automatic word_t itype(logic [11:0] imm, regaddr_t rs1, logic [2:0] f3,
                                    regaddr_t rd, logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic word_t stype(logic [11:0] imm, regaddr_t rs2, regaddr_t rs1,
                                    logic [2:0] f3);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'b0100011};
    endfunction

    function automatic word_t btype(logic [12:0] imm, regaddr_t rs2, regaddr_t rs1,
                                    logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
    endfunction

    function automatic word_t jtype(logic [20:0] imm, regaddr_t rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
    endfunction

    // priority ex, ma, wb, then register file
    function automatic word_t operand(regaddr_t r);
        if (r == 0)
            return '0;
        if (ex_p.valid && ex_p.addr == r)
            return ex_p.data;
        if (ma_p.valid && ma_p.addr == r)
            return ma_p.data;
        if (wb_p.valid && wb_p.addr == r)
            return wb_p.data;
        return shadow[r];
    endfunction

    function automatic id_ex_t bubble();
        id_ex_t e;
        e          = '0;
        e.pc       = `NOP_PC;
        e.ir       = `NOP_IR;
        e.alu_mode = ALU_ADD;
        e.ma_mode  = MA_NONE;
        e.wb_src   = WB_NONE;
        return e;
    endfunction

    function automatic id_ex_t make_ex(word_t ir, word_t op1, word_t op2, alu_mode_t mode,
                                       ma_mode_t ma, wb_src_t wb);
        id_ex_t e;
        e.pc       = cur_pc;
        e.ir       = ir;
        e.alu_op1  = op1;
        e.alu_op2  = op2;
        e.alu_mode = mode;
        e.ma_mode  = ma;
        e.ma_size  = ir[14:12];
        e.ma_data  = operand(ir[24:20]);  // store data, whatever sits in the rs2 field
        e.wb_src   = wb;
        e.wb_data  = cur_pc + 32'd4;
        e.wb_valid = (wb != WB_NONE) && (ir[11:7] != 0);
        e.halt     = 1'b0;
        return e;
    endfunction

    task automatic drive(word_t ir, id_ex_t ex_exp, logic jv, word_t ja, logic rdy);
        pc_i     <= cur_pc;
        ir_i     <= ir;
        ex_fwd_i <= ex_p;
        ma_fwd_i <= ma_p;
        wb_i     <= wb_p;
        exp_ex   <= ex_exp;
        exp_jv   <= jv;
        exp_ja   <= ja;
        exp_rdy  <= rdy;
        tid      <= cur_test;
        chk      <= 1'b1;
        if (wb_p.valid && wb_p.addr != 0)
            shadow[wb_p.addr] = wb_p.data;
        if (rdy)
            cur_pc = cur_pc + 32'd4;  // a stalled instruction is held
    endtask

    task automatic issue(word_t ir, id_ex_t ex_exp, logic jv, word_t ja, logic rdy);
        @(posedge clk_i);
        drive(ir, ex_exp, jv, ja, rdy);
    endtask

    task automatic write_reg(regaddr_t r, word_t v);
        wb_p = '{1'b1, r, v};
        issue(`NOP_IR, make_ex(`NOP_IR, '0, '0, ALU_ADD, MA_NONE, WB_ALU), 1'b0, '0, 1'b1);
        wb_p = '0;
    endtask

    task automatic r_issue(logic [6:0] f7, regaddr_t rs2, regaddr_t rs1, logic [2:0] f3,
                           regaddr_t rd);
        word_t ir;
        ir = rtype(f7, rs2, rs1, f3, rd, OP);
        issue(ir, make_ex(ir, operand(rs1), operand(rs2), {f7[0], f7[5], f3}, MA_NONE,
                          WB_ALU), 1'b0, '0, 1'b1);
    endtask

    task automatic i_issue(logic [11:0] imm, regaddr_t rs1, logic [2:0] f3, regaddr_t rd);
        word_t     ir;
        alu_mode_t mode;
        ir   = itype(imm, rs1, f3, rd, OP_IMM);
        mode = (f3[1:0] == 2'b01) ? {imm[5], imm[10], f3} : {2'b00, f3};  // shifts keep funct7
        issue(ir, make_ex(ir, operand(rs1), sext12(imm), mode, MA_NONE, WB_ALU),
              1'b0, '0, 1'b1);
    endtask

    initial begin
        word_t       a;
        word_t       b;
        word_t       r;
        word_t       ir;
        id_ex_t      e;
        logic [12:0] boff;
        logic [20:0] joff;
        logic [2:0]  f3;
        logic        taken;
        logic [2:0]  conds [0:5];

        conds     = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};
        lcg_state = 32'd45;
        cur_pc    = 32'h0000_1000;
        cur_test  = T_RESET;
        err_ex    = 0;
        err_jmp   = 0;
        err_rdy   = 0;
        ex_p      = '0;
        ma_p      = '0;
        wb_p      = '0;
        for (int i = 0; i < 32; i++)
            shadow[i] = '0;

        // jal on the bus during reset must not redirect
        reset_i  = 1'b1;
        pc_i     = cur_pc;
        ir_i     = jtype(21'h40, 5'd1);
        ex_fwd_i = '0;
        ma_fwd_i = '0;
        wb_i     = '0;
        exp_ex   = bubble();
        exp_jv   = 1'b0;
        exp_ja   = '0;
        exp_rdy  = 1'b1;
        tid      = T_RESET;
        chk      = 1'b1;
        chk_d    = 1'b0;
        @(posedge clk_i);
        // stalled jalr in the second reset cycle, fetch still sees ready
        ir_i     <= itype(12'h010, 5'd5, 3'd0, 5'd1, OP_JALR);
        ex_fwd_i <= '{1'b1, 1'b0, 5'd5, 32'h0};
        @(posedge clk_i);
        reset_i <= 1'b0;
        drive(`NOP_IR, make_ex(`NOP_IR, '0, '0, ALU_ADD, MA_NONE, WB_ALU), 1'b0, '0, 1'b1);

        cur_test = T_ALU;
        for (int k = 1; k <= 8; k++)
            write_reg(regaddr_t'(k), rand_word());
        write_reg(5'd0, 32'hdead_beef);  // x0 ignores it
        r_issue(7'h00, 5'd2, 5'd1, 3'd0, 5'd9);   // add
        r_issue(7'h20, 5'd4, 5'd3, 3'd0, 5'd10);  // sub
        r_issue(7'h00, 5'd6, 5'd5, 3'd3, 5'd0);   // sltu to x0, no writeback
        r_issue(7'h01, 5'd8, 5'd7, 3'd0, 5'd11);  // mul
        r = rand_word();
        i_issue(r[11:0], 5'd5, 3'd0, 5'd12);
        i_issue(r[23:12], 5'd6, 3'd7, 5'd13);
        i_issue({7'b0100000, 5'd7}, 5'd6, 3'd5, 5'd14);  // srai
        i_issue({7'b0000000, 5'd3}, 5'd2, 3'd1, 5'd15);  // slli
        ir = {r[31:12], 5'd13, OP_LUI};
        issue(ir, make_ex(ir, {r[31:12], 12'b0}, '0, ALU_COPY1, MA_NONE, WB_ALU),
              1'b0, '0, 1'b1);
        ir = {r[31:12], 5'd14, OP_AUIPC};
        issue(ir, make_ex(ir, {r[31:12], 12'b0}, cur_pc, ALU_ADD, MA_NONE, WB_ALU),
              1'b0, '0, 1'b1);

        // same source on every port, then peel them off
        cur_test = T_FWD;
        ex_p = '{1'b1, 1'b1, 5'd7, rand_word()};
        ma_p = '{1'b1, 1'b1, 5'd7, rand_word()};
        wb_p = '{1'b1, 5'd7, rand_word()};
        i_issue(12'h000, 5'd7, 3'd0, 5'd16);
        ex_p = '0;
        i_issue(12'h000, 5'd7, 3'd0, 5'd16);
        ma_p      = '0;
        wb_p.data = rand_word();
        i_issue(12'h000, 5'd7, 3'd0, 5'd16);
        wb_p = '0;
        i_issue(12'h000, 5'd7, 3'd0, 5'd16);
        ex_p = '{1'b1, 1'b1, 5'd0, rand_word()};
        i_issue(12'h005, 5'd0, 3'd0, 5'd16);
        ex_p = '0;

        // load-use stalls, then the same instruction goes through
        cur_test = T_HAZ;
        a    = rand_word();
        r    = rand_word();
        ex_p = '{1'b1, 1'b0, 5'd5, a};
        ir   = itype(r[11:0], 5'd5, 3'd0, 5'd1, OP_JALR);
        issue(ir, bubble(), 1'b0, '0, 1'b0);
        ex_p.ready = 1'b1;
        issue(ir, make_ex(ir, '0, '0, ALU_ADD, MA_NONE, WB_PC4), 1'b1,
              a + sext12(r[11:0]), 1'b1);
        ex_p = '0;
        ma_p = '{1'b1, 1'b0, 5'd3, rand_word()};
        issue(rtype(7'h00, 5'd3, 5'd2, 3'd0, 5'd9, OP), bubble(), 1'b0, '0, 1'b0);
        ma_p.ready = 1'b1;
        r_issue(7'h00, 5'd3, 5'd2, 3'd0, 5'd9);
        ma_p = '0;

        cur_test = T_BR;
        for (int k = 0; k < N_BRANCH; k++) begin
            f3 = conds[k % 6];
            a  = rand_word();
            b  = rand_word();
            if (k / 6 == 1)
                b = a;
            else if (k / 6 == 2)
                b = a ^ 32'h8000_0000;  // signed and unsigned order disagree
            r    = rand_word();
            boff = {r[11:0], 1'b0};
            ex_p = '{1'b1, 1'b1, 5'd10, a};
            ma_p = '{1'b1, 1'b1, 5'd11, b};
            case (f3)
                3'd0:    taken = (a == b);
                3'd1:    taken = (a != b);
                3'd4:    taken = ($signed(a) < $signed(b));
                3'd5:    taken = ($signed(a) >= $signed(b));
                3'd6:    taken = (a < b);
                default: taken = (a >= b);
            endcase
            ir = btype(boff, 5'd11, 5'd10, f3);
            issue(ir, make_ex(ir, '0, '0, {2'b00, f3}, MA_NONE, WB_NONE), taken,
                  cur_pc + {{19{boff[12]}}, boff}, 1'b1);
        end
        ex_p = '0;
        ma_p = '0;
        r    = rand_word();
        joff = {r[20:1], 1'b0};
        ir   = jtype(joff, 5'd1);
        issue(ir, make_ex(ir, '0, '0, ALU_ADD, MA_NONE, WB_PC4), 1'b1,
              cur_pc + {{11{joff[20]}}, joff}, 1'b1);
        ir = itype(r[31:20], 5'd3, 3'd0, 5'd0, OP_JALR);  // rd x0, no link
        issue(ir, make_ex(ir, '0, '0, ALU_ADD, MA_NONE, WB_PC4), 1'b1,
              operand(5'd3) + sext12(r[31:20]), 1'b1);

        cur_test = T_MEM;
        r  = rand_word();
        ir = itype(r[11:0], 5'd4, 3'd2, 5'd17, OP_LOAD);   // lw
        issue(ir, make_ex(ir, operand(5'd4), sext12(r[11:0]), ALU_ADD, MA_LOAD, WB_MEM),
              1'b0, '0, 1'b1);
        ir = itype(r[23:12], 5'd2, 3'd4, 5'd18, OP_LOAD);  // lbu
        issue(ir, make_ex(ir, operand(5'd2), sext12(r[23:12]), ALU_ADD, MA_LOAD, WB_MEM),
              1'b0, '0, 1'b1);
        ir = stype(r[11:0], 5'd5, 5'd6, 3'd2);   // sw
        issue(ir, make_ex(ir, operand(5'd6), sext12(r[11:0]), ALU_ADD, MA_STORE, WB_NONE),
              1'b0, '0, 1'b1);
        ir = stype(r[31:20], 5'd8, 5'd1, 3'd0);  // sb
        issue(ir, make_ex(ir, operand(5'd1), sext12(r[31:20]), ALU_ADD, MA_STORE, WB_NONE),
              1'b0, '0, 1'b1);
        ir     = 32'h0000_007f;  // unknown opcode
        e      = make_ex(ir, '0, '0, ALU_ADD, MA_NONE, WB_NONE);
        e.halt = 1'b1;
        issue(ir, e, 1'b0, '0, 1'b1);
        ir     = 32'h0000_0073;  // ecall
        e      = make_ex(ir, '0, '0, ALU_ADD, MA_NONE, WB_NONE);
        e.halt = 1'b1;
        issue(ir, e, 1'b0, '0, 1'b1);

        @(posedge clk_i);
        chk <= 1'b0;
        repeat (3) @(posedge clk_i);
        $display("errors: id_ex %0d, jump %0d, ready %0d", err_ex, err_jmp, err_rdy);
        if (err_ex + err_jmp + err_rdy == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

/* project.f */
+incdir+src
src/decode_pkg.sv
src/instr_decoder.sv
src/regfile.sv
src/operand_bypass.sv
src/branch_unit.sv
src/decode_stage.sv
verification/decode_stage_tb.sv
